//--- run.sh
#!/bin/sh
# compile the RTL and testbench with Verilator, run, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_pr_accel -f tb.f -o sim_pr_accel \
  && ./obj_dir/sim_pr_accel > sim.log 2>&1 \
  || echo "run.sh: build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "TESTS PASSED" sim.log \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

//--- src/pr_accel_top.sv
// delta PageRank accelerator control shell, top level
// host decode, phase sequencing, read routing and result packing
`timescale 1ns/100ps

module pr_accel_top #(
  parameter int CHANNEL_NUM = 4,
  parameter int CORE_NUM = 4
) (
  input  logic ap_clk,
  input  logic areset,

  // host control
  input  logic ap_start,
  input  pr_pkg::byte_addr_t [CHANNEL_NUM-1:0] base_ptr,
  output logic ap_idle,
  output logic ap_done,
  output logic ap_ready,

  // graph pipeline side
  input  pr_pkg::rd_req_t [CHANNEL_NUM-1:0] load_req,
  input  pr_pkg::rd_req_t [CHANNEL_NUM-1:0] edge_req,
  input  logic [CORE_NUM-1:0] transfer_complete,
  input  logic [CORE_NUM-1:0] iteration_done,
  input  pr_pkg::wb_line_t [CHANNEL_NUM-1:0] wb_in,
  input  logic transfer_done,
  input  logic [CHANNEL_NUM-1:0] write_empty,
  output pr_pkg::mem_rd_t [CHANNEL_NUM-1:0] mem_rd,
  output pr_pkg::wb_line_t [CHANNEL_NUM-1:0] wb_out,
  output logic core_rst,
  output logic offset_rst
);

  logic start_pulse;
  logic done_pulse;
  pr_pkg::byte_addr_t [CHANNEL_NUM-1:0] base_ptr_q;
  pr_pkg::phase_e phase;
  logic cycle_valid;
  pr_pkg::cycle_cnt_t cycle_count;
  logic all_drained;

  pr_host_ctrl #(
    .CHANNEL_NUM(CHANNEL_NUM)
  ) u_host_ctrl (
    .ap_clk(ap_clk),
    .areset(areset),
    .ap_start(ap_start),
    .base_ptr(base_ptr),
    .done_pulse(done_pulse),
    .start_pulse(start_pulse),
    .base_ptr_q(base_ptr_q),
    .ap_idle(ap_idle),
    .ap_done(ap_done),
    .ap_ready(ap_ready)
  );

  pr_phase_sequencer #(
    .CORE_NUM(CORE_NUM)
  ) u_phase_sequencer (
    .ap_clk(ap_clk),
    .areset(areset),
    .start_pulse(start_pulse),
    .transfer_complete(transfer_complete),
    .iteration_done(iteration_done),
    .transfer_done(transfer_done),
    .all_drained(all_drained),
    .phase(phase),
    .core_rst(core_rst),
    .offset_rst(offset_rst),
    .cycle_valid(cycle_valid),
    .done_pulse(done_pulse),
    .cycle_count(cycle_count)
  );

  pr_channel_router #(
    .CHANNEL_NUM(CHANNEL_NUM)
  ) u_channel_router (
    .ap_clk(ap_clk),
    .areset(areset),
    .phase(phase),
    .base_ptr_q(base_ptr_q),
    .load_req(load_req),
    .edge_req(edge_req),
    .mem_rd(mem_rd)
  );

  pr_writeback_packer #(
    .CHANNEL_NUM(CHANNEL_NUM)
  ) u_writeback_packer (
    .ap_clk(ap_clk),
    .areset(areset),
    .phase(phase),
    .cycle_valid(cycle_valid),
    .cycle_count(cycle_count),
    .wb_in(wb_in),
    .write_empty(write_empty),
    .wb_out(wb_out),
    .all_drained(all_drained)
  );

endmodule

//--- src/pr_channel_router.sv
// per-channel read router: offset loads in PH_LOAD, edge reads
// in PH_RUN, line index converted to a byte address
`timescale 1ns/100ps

module pr_channel_router #(
  parameter int CHANNEL_NUM = 4
) (
  input  logic ap_clk,
  input  logic areset,
  input  pr_pkg::phase_e phase,
  input  pr_pkg::byte_addr_t [CHANNEL_NUM-1:0] base_ptr_q,
  input  pr_pkg::rd_req_t [CHANNEL_NUM-1:0] load_req,
  input  pr_pkg::rd_req_t [CHANNEL_NUM-1:0] edge_req,
  output pr_pkg::mem_rd_t [CHANNEL_NUM-1:0] mem_rd
);

  pr_pkg::rd_req_t [CHANNEL_NUM-1:0] sel_req;
  logic [CHANNEL_NUM-1:0] rd_vld_q;
  pr_pkg::byte_addr_t [CHANNEL_NUM-1:0] rd_addr_q;

  // request source by phase, everything else dropped
  always_comb begin
    for (int c = 0; c < CHANNEL_NUM; c++) begin
      case (phase)
        pr_pkg::PH_LOAD: sel_req[c] = load_req[c];
        pr_pkg::PH_RUN: sel_req[c] = edge_req[c];
        default: sel_req[c] = '0;
      endcase
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      rd_vld_q <= '0;
    end else begin
      for (int c = 0; c < CHANNEL_NUM; c++) begin
        rd_vld_q[c] <= sel_req[c].valid;
      end
    end
  end

  // base + idx * line bytes
  always_ff @(posedge ap_clk) begin
    for (int c = 0; c < CHANNEL_NUM; c++) begin
      if (sel_req[c].valid) begin
        rd_addr_q[c] <= base_ptr_q[c]
          + (pr_pkg::byte_addr_t'(sel_req[c].idx) << pr_pkg::LINE_BYTES_LOG2);
      end
    end
  end

  for (genvar c = 0; c < CHANNEL_NUM; c++) begin : g_out
    assign mem_rd[c] = '{addr: rd_addr_q[c], valid: rd_vld_q[c]};
  end

  no_rd_after_idle: assert property (
    @(posedge ap_clk) disable iff (areset)
    ($past(phase) == pr_pkg::PH_IDLE) |-> (rd_vld_q == '0)
  );

endmodule

//--- src/pr_host_ctrl.sv
// host control decode: turns ap_start into a launch pulse,
// latches channel base pointers, drives ap_idle/ap_done/ap_ready
`timescale 1ns/100ps

module pr_host_ctrl #(
  parameter int CHANNEL_NUM = 4
) (
  input  logic ap_clk,
  input  logic areset,
  input  logic ap_start,
  input  pr_pkg::byte_addr_t [CHANNEL_NUM-1:0] base_ptr,
  input  logic done_pulse,
  output logic start_pulse,
  output pr_pkg::byte_addr_t [CHANNEL_NUM-1:0] base_ptr_q,
  output logic ap_idle,
  output logic ap_done,
  output logic ap_ready
);

  logic ap_start_r;
  logic idle_q;

  // rising edge of ap_start, accepted only while idle
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ap_start_r <= 1'b0;
      start_pulse <= 1'b0;
    end else begin
      ap_start_r <= ap_start;
      start_pulse <= ap_start & ~ap_start_r & idle_q & ~start_pulse;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      idle_q <= 1'b1;
    end else if (done_pulse) begin
      idle_q <= 1'b1;
    end else if (start_pulse) begin
      idle_q <= 1'b0;
    end
  end

  // pointers held for the whole run
  always_ff @(posedge ap_clk) begin
    if (start_pulse) begin
      base_ptr_q <= base_ptr;
    end
  end

  assign ap_idle = idle_q;

  // non-pipelined kernel: ready with done
  assign ap_done = done_pulse;
  assign ap_ready = done_pulse;

  // a launch never lands on the cycle the sequencer finishes
  start_done_apart: assert property (
    @(posedge ap_clk) disable iff (areset)
    !(start_pulse && done_pulse)
  );

endmodule

//--- src/pr_phase_sequencer.sv
// phase sequencer: idle, offset load, iterations, write-back,
// plus the core/offset-store reset levels and run-cycle counter
`timescale 1ns/100ps

module pr_phase_sequencer #(
  parameter int CORE_NUM = 4
) (
  input  logic ap_clk,
  input  logic areset,
  input  logic start_pulse,
  input  logic [CORE_NUM-1:0] transfer_complete,
  input  logic [CORE_NUM-1:0] iteration_done,
  input  logic transfer_done,
  input  logic all_drained,
  output pr_pkg::phase_e phase,
  output logic core_rst,
  output logic offset_rst,
  output logic cycle_valid,
  output logic done_pulse,
  output pr_pkg::cycle_cnt_t cycle_count
);

  logic load_end;
  logic run_end;
  logic wb_end;

  assign load_end = &transfer_complete;
  assign run_end = &iteration_done;
  assign wb_end = transfer_done & all_drained;

  ////////////////////////////////////////////////////////////
  // phase FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      phase <= pr_pkg::PH_IDLE;
      cycle_valid <= 1'b0;
      done_pulse <= 1'b0;
    end else begin
      cycle_valid <= 1'b0;
      done_pulse <= 1'b0;
      case (phase)
        pr_pkg::PH_IDLE: begin
          if (start_pulse) begin
            phase <= pr_pkg::PH_LOAD;
          end
        end
        pr_pkg::PH_LOAD: begin
          if (load_end) begin
            phase <= pr_pkg::PH_RUN;
          end
        end
        pr_pkg::PH_RUN: begin
          if (run_end) begin
            phase <= pr_pkg::PH_WRITEBACK;
            cycle_valid <= 1'b1;
          end
        end
        pr_pkg::PH_WRITEBACK: begin
          // back to idle so the kernel can be relaunched
          if (wb_end) begin
            phase <= pr_pkg::PH_IDLE;
            done_pulse <= 1'b1;
          end
        end
        default: phase <= pr_pkg::PH_IDLE;
      endcase
    end
  end

  // cores only run in PH_RUN, offset store only held in idle
  assign core_rst = (phase != pr_pkg::PH_RUN);
  assign offset_rst = (phase == pr_pkg::PH_IDLE);

  ////////////////////////////////////////////////////////////
  // run-cycle counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      cycle_count <= '0;
    end else if (start_pulse) begin
      cycle_count <= '0;
    end else if (phase == pr_pkg::PH_RUN && !run_end) begin
      cycle_count <= cycle_count + pr_pkg::cycle_cnt_t'(1);
    end
  end

  // the record strobe belongs to the run -> write-back step only
  cycle_valid_on_entry: assert property (
    @(posedge ap_clk) disable iff (areset)
    cycle_valid |-> (phase == pr_pkg::PH_WRITEBACK) && ($past(phase) == pr_pkg::PH_RUN)
  );

endmodule

//--- src/pr_pkg.sv
// shared widths, types and phase encoding for the delta
// PageRank control shell
package pr_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////
  parameter int ADDR_WIDTH = 64;
  parameter int LINE_IDX_WIDTH = 32;

  // 32-bit id plus 32-bit value
  parameter int VERTEX_WIDTH = 64;
  parameter int LANE_NUM = 2;
  parameter int LINE_WIDTH = VERTEX_WIDTH * LANE_NUM;

  // line index to byte offset
  parameter int LINE_BYTES_LOG2 = $clog2(LINE_WIDTH / 8);
  parameter int CYCLE_WIDTH = 32;

  ////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////
  typedef logic [ADDR_WIDTH-1:0] byte_addr_t;
  typedef logic [LINE_IDX_WIDTH-1:0] line_idx_t;
  typedef logic [LINE_WIDTH-1:0] line_t;
  typedef logic [CYCLE_WIDTH-1:0] cycle_cnt_t;

  // kernel phases
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_LOAD,
    PH_RUN,
    PH_WRITEBACK
  } phase_e;

  ////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    line_idx_t idx;
    logic valid;
  } rd_req_t;

  typedef struct packed {
    byte_addr_t addr;
    logic valid;
  } mem_rd_t;

  typedef struct packed {
    line_t data;
    logic valid;
  } wb_line_t;

endpackage

//--- src/pr_writeback_packer.sv
// write-back packer: forwards result lines, slips the run-cycle
// record onto channel 0 and tracks per-channel write drain
`timescale 1ns/100ps

module pr_writeback_packer #(
  parameter int CHANNEL_NUM = 4
) (
  input  logic ap_clk,
  input  logic areset,
  input  pr_pkg::phase_e phase,
  input  logic cycle_valid,
  input  pr_pkg::cycle_cnt_t cycle_count,
  input  pr_pkg::wb_line_t [CHANNEL_NUM-1:0] wb_in,
  input  logic [CHANNEL_NUM-1:0] write_empty,
  output pr_pkg::wb_line_t [CHANNEL_NUM-1:0] wb_out,
  output logic all_drained
);

  logic [CHANNEL_NUM-1:0] wb_vld_q;
  pr_pkg::line_t [CHANNEL_NUM-1:0] wb_data_q;
  logic [CHANNEL_NUM-1:0] drained_q;
  pr_pkg::line_t cycle_line;

  // count in the low bits, rest zero
  assign cycle_line = pr_pkg::line_t'(cycle_count);

  ////////////////////////////////////////////////////////////
  // result lines
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      wb_vld_q <= '0;
    end else begin
      for (int c = 0; c < CHANNEL_NUM; c++) begin
        wb_vld_q[c] <= wb_in[c].valid;
      end
      if (cycle_valid) begin
        wb_vld_q[0] <= 1'b1;
      end
    end
  end

  // channel 0 line is overwritten by the record that cycle
  always_ff @(posedge ap_clk) begin
    for (int c = 0; c < CHANNEL_NUM; c++) begin
      wb_data_q[c] <= wb_in[c].data;
    end
    if (cycle_valid) begin
      wb_data_q[0] <= cycle_line;
    end
  end

  for (genvar c = 0; c < CHANNEL_NUM; c++) begin : g_out
    assign wb_out[c] = '{data: wb_data_q[c], valid: wb_vld_q[c]};
  end

  ////////////////////////////////////////////////////////////
  // drain tracking
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      drained_q <= '0;
    end else if (phase == pr_pkg::PH_IDLE) begin
      drained_q <= '0;
    end else if (phase == pr_pkg::PH_WRITEBACK) begin
      drained_q <= drained_q | write_empty;
    end
  end

  assign all_drained = &drained_q;

endmodule

//--- tb.f
src/pr_pkg.sv
src/pr_host_ctrl.sv
src/pr_phase_sequencer.sv
src/pr_channel_router.sv
src/pr_writeback_packer.sv
src/pr_accel_top.sv
test/tb_clock_gen.sv
test/tb_pr_accel.sv

//--- test/tb_clock_gen.sv
// clock and reset source for the testbench
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic ap_clk,
  output logic areset
);

  initial begin
    ap_clk = 1'b0;
    forever #(PERIOD_NS / 2) ap_clk = ~ap_clk;
  end

  initial begin
    areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge ap_clk);
    areset <= 1'b0;
  end

endmodule

//--- test/tb_pr_accel.sv
// testbench for the delta PageRank control shell: plays host and
// graph pipeline, checks read routing, write-back and run records
`timescale 1ns/100ps

module tb_pr_accel;

  localparam int CHANNEL_NUM = 4;
  localparam int CORE_NUM = 4;
  localparam int RUNS = 2;
  localparam int IDLE_CYCLES = 8;
  localparam int LOAD_MIN = 4;
  localparam int RUN_MIN = 5;
  localparam int WB_MIN = 4;
  // random spans of 8 or 16 cycles on top of each minimum
  localparam int RUN_CYCLES_MAX = 16 + (LOAD_MIN + 8) + (RUN_MIN + 16) + (WB_MIN + 8);
  localparam int WATCHDOG_CYCLES = 2 * (10 + IDLE_CYCLES + RUNS * RUN_CYCLES_MAX);
  localparam pr_pkg::byte_addr_t LINE_BYTES = pr_pkg::byte_addr_t'(pr_pkg::LINE_WIDTH / 8);

  logic ap_clk;
  logic areset;
  logic ap_start;
  pr_pkg::byte_addr_t [CHANNEL_NUM-1:0] base_ptr;
  logic ap_idle;
  logic ap_done;
  logic ap_ready;
  pr_pkg::rd_req_t [CHANNEL_NUM-1:0] load_req;
  pr_pkg::rd_req_t [CHANNEL_NUM-1:0] edge_req;
  logic [CORE_NUM-1:0] transfer_complete;
  logic [CORE_NUM-1:0] iteration_done;
  pr_pkg::wb_line_t [CHANNEL_NUM-1:0] wb_in;
  logic transfer_done;
  logic [CHANNEL_NUM-1:0] write_empty;
  pr_pkg::mem_rd_t [CHANNEL_NUM-1:0] mem_rd;
  pr_pkg::wb_line_t [CHANNEL_NUM-1:0] wb_out;
  logic core_rst;
  logic offset_rst;

  integer seed = 33842;
  int fail_count = 0;
  int records_seen = 0;

  // expected outputs for the next edge
  pr_pkg::mem_rd_t [CHANNEL_NUM-1:0] exp_rd;
  pr_pkg::wb_line_t [CHANNEL_NUM-1:0] exp_wb;
  logic exp_done;
  logic exp_idle;
  logic start_due;
  logic start_prev;
  logic launch;
  logic rec_pending;
  logic rec_check;
  logic [CHANNEL_NUM-1:0] drain_seen;
  pr_pkg::cycle_cnt_t run_edges;
  pr_pkg::cycle_cnt_t rec_count;
  pr_pkg::phase_e cur_phase;

  tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(5)) u_clock_gen (
    .ap_clk(ap_clk),
    .areset(areset)
  );

  pr_accel_top #(
    .CHANNEL_NUM(CHANNEL_NUM),
    .CORE_NUM(CORE_NUM)
  ) DUT (.*);

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////
  function automatic pr_pkg::byte_addr_t ref_addr(input pr_pkg::byte_addr_t base,
                                                  input pr_pkg::line_idx_t idx);
    return base + pr_pkg::byte_addr_t'(idx) * LINE_BYTES;
  endfunction

  function automatic pr_pkg::line_t ref_record(input pr_pkg::cycle_cnt_t cnt);
    pr_pkg::line_t line;
    line = '0;
    line[pr_pkg::CYCLE_WIDTH-1:0] = cnt;
    return line;
  endfunction

  task automatic report_fail(input string msg);
    fail_count++;
    $display("Fail at %0t: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_mem_rd(input pr_pkg::mem_rd_t got, input pr_pkg::mem_rd_t exp,
                              input int ch);
    if (got.valid !== exp.valid || (exp.valid && got.addr !== exp.addr)) begin
      report_fail($sformatf("mem_rd[%0d] got v=%b a=%h, expected v=%b a=%h",
                            ch, got.valid, got.addr, exp.valid, exp.addr));
    end
  endtask

  task automatic check_wb(input pr_pkg::wb_line_t got, input pr_pkg::wb_line_t exp,
                          input int ch);
    if (got.valid !== exp.valid || (exp.valid && got.data !== exp.data)) begin
      report_fail($sformatf("wb_out[%0d] got v=%b d=%h, expected v=%b d=%h",
                            ch, got.valid, got.data, exp.valid, exp.data));
    end
  endtask

  task automatic check_count(input pr_pkg::cycle_cnt_t got, input pr_pkg::cycle_cnt_t exp);
    if (got !== exp) begin
      report_fail($sformatf("cycle record %0d, expected %0d", got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_fail($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compare process
  ////////////////////////////////////////////////////////////
  always @(posedge ap_clk) begin
    if (areset) begin
      exp_rd = '0;
      exp_wb = '0;
      exp_done = 1'b0;
      exp_idle = 1'b1;
      start_due = 1'b0;
      start_prev = 1'b0;
      cur_phase = pr_pkg::PH_IDLE;
      rec_pending = 1'b0;
      rec_check = 1'b0;
      drain_seen = '0;
      run_edges = '0;
    end else begin
      if (rec_check) begin
        check_count(wb_out[0].data[pr_pkg::CYCLE_WIDTH-1:0], rec_count);
        records_seen++;
        rec_check = 1'b0;
      end
      for (int c = 0; c < CHANNEL_NUM; c++) begin
        check_mem_rd(mem_rd[c], exp_rd[c], c);
        check_wb(wb_out[c], exp_wb[c], c);
      end
      check_flag(ap_done, exp_done, "ap_done");
      check_flag(ap_ready, exp_done, "ap_ready");
      check_flag(ap_idle, exp_idle, "ap_idle");
      check_flag(core_rst, cur_phase != pr_pkg::PH_RUN, "core_rst");
      check_flag(offset_rst, cur_phase == pr_pkg::PH_IDLE, "offset_rst");

      for (int c = 0; c < CHANNEL_NUM; c++) begin
        exp_rd[c] = '0;
        if (cur_phase == pr_pkg::PH_LOAD && load_req[c].valid) begin
          exp_rd[c] = '{addr: ref_addr(base_ptr[c], load_req[c].idx), valid: 1'b1};
        end else if (cur_phase == pr_pkg::PH_RUN && edge_req[c].valid) begin
          exp_rd[c] = '{addr: ref_addr(base_ptr[c], edge_req[c].idx), valid: 1'b1};
        end
        exp_wb[c] = wb_in[c];
      end
      // record takes channel 0 one cycle after the run ends
      if (rec_pending) begin
        exp_wb[0] = '{data: ref_record(run_edges), valid: 1'b1};
        rec_count = run_edges;
        rec_check = 1'b1;
        rec_pending = 1'b0;
      end

      // host decode: launch one cycle after a rising ap_start while idle
      launch = start_due;
      start_due = ap_start && !start_prev && exp_idle && !start_due;
      start_prev = ap_start;
      if (exp_done) begin
        exp_idle = 1'b1;
      end else if (launch) begin
        exp_idle = 1'b0;
      end

      // phase model
      exp_done = 1'b0;
      case (cur_phase)
        pr_pkg::PH_IDLE: begin
          drain_seen = '0;
          run_edges = '0;
          if (launch) begin
            cur_phase = pr_pkg::PH_LOAD;
          end
        end
        pr_pkg::PH_LOAD: begin
          if (transfer_complete == '1) begin
            cur_phase = pr_pkg::PH_RUN;
          end
        end
        pr_pkg::PH_RUN: begin
          if (iteration_done == '1) begin
            rec_pending = 1'b1;
            cur_phase = pr_pkg::PH_WRITEBACK;
          end else begin
            run_edges = run_edges + pr_pkg::cycle_cnt_t'(1);
          end
        end
        default: begin
          exp_done = transfer_done && (drain_seen == '1);
          drain_seen = drain_seen | write_empty;
          if (exp_done) begin
            cur_phase = pr_pkg::PH_IDLE;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////
  task automatic step();
    @(posedge ap_clk);
    for (int c = 0; c < CHANNEL_NUM; c++) begin
      load_req[c].idx <= pr_pkg::line_idx_t'($random(seed));
      load_req[c].valid <= 1'($random(seed));
      edge_req[c].idx <= pr_pkg::line_idx_t'($random(seed));
      edge_req[c].valid <= 1'($random(seed));
    end
  endtask

  task automatic drive_wb_lines(input logic active);
    for (int c = 0; c < CHANNEL_NUM; c++) begin
      wb_in[c].data <= pr_pkg::line_t'({$random(seed), $random(seed),
                                        $random(seed), $random(seed)});
      wb_in[c].valid <= active & 1'($random(seed));
    end
  endtask

  task automatic run_kernel();
    int load_len;
    int run_len;
    int wb_len;
    load_len = LOAD_MIN + {$random(seed)} % 8;
    run_len = RUN_MIN + {$random(seed)} % 16;
    wb_len = WB_MIN + {$random(seed)} % 8;

    step();
    for (int c = 0; c < CHANNEL_NUM; c++) begin
      base_ptr[c] <= pr_pkg::byte_addr_t'({$random(seed), $random(seed)});
    end
    ap_start <= 1'b1;
    step();
    ap_start <= 1'b0;
    while (ap_idle) step();

    // offset load, cores finish one by one
    repeat (load_len) begin
      step();
      transfer_complete <= CORE_NUM'($random(seed)) & ~CORE_NUM'(1);
    end
    step();
    transfer_complete <= '1;
    while (core_rst) step();
    transfer_complete <= '0;

    // iterations, never all cores done until the end
    repeat (run_len) begin
      step();
      iteration_done <= CORE_NUM'($random(seed)) & ~CORE_NUM'(1);
    end
    step();
    iteration_done <= '1;
    while (!core_rst) step();
    iteration_done <= '0;

    // write-back, channel 0 stays busy until the end
    repeat (wb_len) begin
      step();
      drive_wb_lines(1'b1);
      write_empty <= CHANNEL_NUM'($random(seed)) & ~CHANNEL_NUM'(1);
      transfer_done <= 1'($random(seed));
    end
    step();
    drive_wb_lines(1'b1);
    write_empty <= '1;
    transfer_done <= 1'b1;
    step();
    drive_wb_lines(1'b1);
    write_empty <= '0;
    while (!ap_done) begin
      step();
      drive_wb_lines(1'b1);
    end
    transfer_done <= 1'b0;
    drive_wb_lines(1'b0);
    step();
    check_flag(ap_idle, 1'b1, "ap_idle after done");
  endtask

  initial begin
    ap_start = 1'b0;
    base_ptr = '0;
    load_req = '0;
    edge_req = '0;
    transfer_complete = '0;
    iteration_done = '0;
    wb_in = '0;
    transfer_done = 1'b0;
    write_empty = '0;

    @(posedge ap_clk);
    while (areset) @(posedge ap_clk);
    check_flag(ap_idle, 1'b1, "ap_idle after reset");
    check_flag(core_rst, 1'b1, "core_rst after reset");
    check_flag(offset_rst, 1'b1, "offset_rst after reset");

    // requests while idle must be dropped
    repeat (IDLE_CYCLES) step();
    check_flag(ap_idle, 1'b1, "ap_idle before start");

    repeat (RUNS) run_kernel();
    step();
    step();

    if (records_seen != RUNS) begin
      $display("only %0d cycle records were seen, expected %0d", records_seen, RUNS);
      fail_count++;
    end
    if (fail_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "checks failed");
    end
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
    $display("watchdog expired after %0d cycles, a kernel run did not complete",
             WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule
